// ==== verilog.f ====
+incdir+hw
hw/rename_pkg.sv
hw/phys_reg_file.sv
hw/tag_queue.sv
hw/map_table.sv
hw/ready_table.sv
hw/rename_ctrl.sv
hw/rename_top.sv
bench/rename_tb.sv

// ==== Makefile ====
# Verilator simulation of the rename back end
TOP = rename_tb
LOG = sim.log

.PHONY: sim clean

# Pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) \
	  -Mdir obj_dir -o $(TOP)_sim
	./obj_dir/$(TOP)_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/rename_tb.sv ====
/* Testbench for rename_top. Checks live in concurrent assertions against a model;
   stimulus keeps strobes legal, and reads of never-written tags are not checked. */
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_tb;

  logic clk;
  logic rst_n;
  logic dispatch_i;
  rename_pkg::areg_t src1_areg_i;
  rename_pkg::areg_t src2_areg_i;
  rename_pkg::areg_t dst_areg_i;
  logic writeback_i;
  rename_pkg::preg_t wb_preg_i;
  rename_pkg::data_t wb_data_i;
  logic retire_i;
  logic [`RN_READ_PORT_NUM-1:0] rd_en_i;
  rename_pkg::preg_t [`RN_READ_PORT_NUM-1:0] rd_preg_i;
  logic dispatch_ready_o;
  logic renamed_o;
  rename_pkg::preg_t src1_preg_o;
  rename_pkg::preg_t src2_preg_o;
  logic src1_ready_o;
  logic src2_ready_o;
  rename_pkg::preg_t dst_preg_o;
  rename_pkg::data_t [`RN_READ_PORT_NUM-1:0] rd_data_o;

  int errors = 0;
  logic [31:0] rng_state = 32'd44;

  // Model state
  rename_pkg::preg_t m_map [`RN_ARCH_REG_NUM];
  rename_pkg::data_t m_data [`RN_PHY_REG_NUM];
  logic [`RN_PHY_REG_NUM-1:0] m_ready;
  logic [`RN_PHY_REG_NUM-1:0] m_written;
  rename_pkg::preg_t m_free [$];
  rename_pkg::preg_t m_release [$];
  // Allocated tags still waiting for writeback
  rename_pkg::preg_t pend [$];
  // Expected outputs
  logic exp_renamed;
  logic exp_disp_ready;
  rename_pkg::preg_t exp_src1;
  rename_pkg::preg_t exp_src2;
  rename_pkg::preg_t exp_dst;
  logic exp_src1_rdy;
  logic exp_src2_rdy;
  rename_pkg::data_t [`RN_READ_PORT_NUM-1:0] exp_rd;
  logic [`RN_READ_PORT_NUM-1:0] rd_chk;

  rename_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic drop_pending(input rename_pkg::preg_t tag);
    for (int i = 0; i < pend.size(); i++) begin
      if (pend[i] == tag) begin
        pend.delete(i);
        break;
      end
    end
  endtask

  // ========================================
  // Reference model
  // ========================================

  always @(posedge clk or negedge rst_n) begin : ref_model
    rename_pkg::preg_t new_tag;
    rename_pkg::preg_t rel_tag;
    rename_pkg::preg_t s1;
    rename_pkg::preg_t s2;
    if (!rst_n) begin
      m_free.delete();
      m_release.delete();
      pend.delete();
      for (int i = `RN_ARCH_REG_NUM; i < `RN_PHY_REG_NUM; i++) begin
        m_free.push_back(rename_pkg::preg_t'(i));
      end
      for (int i = 0; i < `RN_ARCH_REG_NUM; i++) begin
        m_map[i] <= rename_pkg::preg_t'(i);
      end
      for (int i = 0; i < `RN_PHY_REG_NUM; i++) begin
        m_ready[i] <= (i < `RN_ARCH_REG_NUM);
      end
      m_written <= '0;
      exp_renamed <= 1'b0;
      exp_disp_ready <= 1'b1;
    end else begin
      exp_renamed <= dispatch_i;
      if (writeback_i) begin
        m_ready[wb_preg_i] <= 1'b1;
        m_data[wb_preg_i] <= wb_data_i;
        m_written[wb_preg_i] <= 1'b1;
        drop_pending(wb_preg_i);
      end
      if (dispatch_i) begin
        // Sources see the map before this dispatch's update
        s1 = m_map[src1_areg_i];
        s2 = m_map[src2_areg_i];
        new_tag = m_free.pop_front();
        exp_src1 <= s1;
        exp_src2 <= s2;
        exp_src1_rdy <= m_ready[s1] | (writeback_i && (wb_preg_i == s1));
        exp_src2_rdy <= m_ready[s2] | (writeback_i && (wb_preg_i == s2));
        exp_dst <= new_tag;
        m_release.push_back(m_map[dst_areg_i]);
        m_map[dst_areg_i] <= new_tag;
        m_ready[new_tag] <= 1'b0;
        pend.push_back(new_tag);
      end
      if (retire_i) begin
        rel_tag = m_release.pop_front();
        m_free.push_back(rel_tag);
        drop_pending(rel_tag);
      end
      exp_disp_ready <= (m_free.size() != 0);
    end
  end

  // Expected read data, bypass first
  always_comb begin
    for (int k = 0; k < `RN_READ_PORT_NUM; k++) begin
      exp_rd[k] = '0;
      rd_chk[k] = 1'b1;
      if (rd_en_i[k]) begin
        if (writeback_i && (wb_preg_i == rd_preg_i[k])) begin
          exp_rd[k] = wb_data_i;
        end else begin
          exp_rd[k] = m_data[rd_preg_i[k]];
          rd_chk[k] = m_written[rd_preg_i[k]];
        end
      end
    end
  end

  // ========================================
  // Checks
  // ========================================

  a_renamed : assert property (@(posedge clk) disable iff (!rst_n)
    renamed_o == exp_renamed) else begin
    errors++;
    $display("ERROR %0t: renamed_o got %0b expected %0b", $time,
             $sampled(renamed_o), $sampled(exp_renamed));
  end
  a_disp_ready : assert property (@(posedge clk) disable iff (!rst_n)
    dispatch_ready_o == exp_disp_ready) else begin
    errors++;
    $display("ERROR %0t: dispatch_ready_o got %0b expected %0b", $time,
             $sampled(dispatch_ready_o), $sampled(exp_disp_ready));
  end
  a_src1 : assert property (@(posedge clk) disable iff (!rst_n)
    renamed_o |-> (src1_preg_o == exp_src1)) else begin
    errors++;
    $display("ERROR %0t: src1_preg_o got %0d expected %0d", $time,
             $sampled(src1_preg_o), $sampled(exp_src1));
  end
  a_src2 : assert property (@(posedge clk) disable iff (!rst_n)
    renamed_o |-> (src2_preg_o == exp_src2)) else begin
    errors++;
    $display("ERROR %0t: src2_preg_o got %0d expected %0d", $time,
             $sampled(src2_preg_o), $sampled(exp_src2));
  end
  a_src1_rdy : assert property (@(posedge clk) disable iff (!rst_n)
    renamed_o |-> (src1_ready_o == exp_src1_rdy)) else begin
    errors++;
    $display("ERROR %0t: src1_ready_o got %0b expected %0b", $time,
             $sampled(src1_ready_o), $sampled(exp_src1_rdy));
  end
  a_src2_rdy : assert property (@(posedge clk) disable iff (!rst_n)
    renamed_o |-> (src2_ready_o == exp_src2_rdy)) else begin
    errors++;
    $display("ERROR %0t: src2_ready_o got %0b expected %0b", $time,
             $sampled(src2_ready_o), $sampled(exp_src2_rdy));
  end
  a_dst : assert property (@(posedge clk) disable iff (!rst_n)
    renamed_o |-> (dst_preg_o == exp_dst)) else begin
    errors++;
    $display("ERROR %0t: dst_preg_o got %0d expected %0d", $time,
             $sampled(dst_preg_o), $sampled(exp_dst));
  end

  for (genvar k = 0; k < `RN_READ_PORT_NUM; k++) begin : g_rd
    a_rd_data : assert property (@(posedge clk) disable iff (!rst_n)
      rd_chk[k] |-> (rd_data_o[k] == exp_rd[k])) else begin
      errors++;
      $display("ERROR %0t: rd_data_o[%0d] got %h expected %h", $time, k,
               $sampled(rd_data_o[k]), $sampled(exp_rd[k]));
    end
  end

  // ========================================
  // Stimulus helpers
  // ========================================

  // Inputs change 1 ns after the edge, strobes default low
  task automatic next_cycle();
    @(posedge clk);
    #1;
    dispatch_i = 1'b0;
    writeback_i = 1'b0;
    retire_i = 1'b0;
    rd_en_i = '0;
  endtask

  task automatic set_dispatch(input rename_pkg::areg_t s1, input rename_pkg::areg_t s2,
                              input rename_pkg::areg_t d);
    dispatch_i = 1'b1;
    src1_areg_i = s1;
    src2_areg_i = s2;
    dst_areg_i = d;
  endtask

  task automatic set_writeback(input rename_pkg::preg_t tag, input rename_pkg::data_t data);
    writeback_i = 1'b1;
    wb_preg_i = tag;
    wb_data_i = data;
  endtask

  task automatic set_read(input int port, input rename_pkg::preg_t tag);
    rd_en_i[port] = 1'b1;
    rd_preg_i[port] = tag;
  endtask

  task automatic wait_dispatch_ready(output logic ready);
    int n;
    n = 0;
    while (!dispatch_ready_o && (n < 50)) begin
      next_cycle();
      n++;
    end
    ready = dispatch_ready_o;
    if (!ready) begin
      errors++;
      $display("Timeout: dispatch_ready_o stayed low for 50 cycles");
    end
  endtask

  task automatic random_dispatch(input logic dst_is_src);
    rename_pkg::areg_t s1;
    logic ready;
    s1 = rename_pkg::areg_t'(next_rand());
    wait_dispatch_ready(ready);
    if (ready) begin
      set_dispatch(s1, rename_pkg::areg_t'(next_rand()),
                   dst_is_src ? s1 : rename_pkg::areg_t'(next_rand()));
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin : stimulus
    logic [31:0] r;
    logic ok;
    rst_n = 1'b1;
    dispatch_i = 1'b0;
    src1_areg_i = '0;
    src2_areg_i = '0;
    dst_areg_i = '0;
    writeback_i = 1'b0;
    wb_preg_i = '0;
    wb_data_i = '0;
    retire_i = 1'b0;
    rd_en_i = '0;
    rd_preg_i = '0;
    #1 rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    next_cycle();

    // Identity sources, fresh tags from 32 up
    set_dispatch(5'd10, 5'd11, 5'd1);
    next_cycle();
    set_dispatch(5'd12, 5'd13, 5'd2);
    next_cycle();
    set_dispatch(5'd14, 5'd15, 5'd3);
    next_cycle();
    // Renamed sources not ready yet
    set_dispatch(5'd1, 5'd2, 5'd4);
    next_cycle();
    set_writeback(m_map[1], next_rand());
    next_cycle();
    set_dispatch(5'd1, 5'd3, 5'd5);
    next_cycle();
    // Writeback alongside dispatch
    set_dispatch(5'd3, 5'd2, 5'd6);
    set_writeback(m_map[3], next_rand());
    next_cycle();

    // Register reads, bypass, idle port
    set_read(0, m_map[1]);
    set_read(1, m_map[3]);
    next_cycle();
    set_writeback(m_map[2], next_rand());
    set_read(0, m_map[2]);
    next_cycle();
    set_read(1, m_map[2]);
    next_cycle();

    // Drain, then exhaust the free queue
    while (m_release.size() != 0) begin
      retire_i = 1'b1;
      next_cycle();
    end
    repeat (`RN_PHY_REG_NUM - `RN_ARCH_REG_NUM) begin
      random_dispatch(1'b0);
      next_cycle();
    end
    next_cycle();
    retire_i = 1'b1;
    next_cycle();
    wait_dispatch_ready(ok);
    while (pend.size() != 0) begin
      set_writeback(pend[0], next_rand());
      next_cycle();
    end

    // Retire order and dst equal to its own source
    repeat (6) begin
      retire_i = 1'b1;
      next_cycle();
    end
    repeat (6) begin
      random_dispatch(1'b1);
      next_cycle();
    end

    // Random mix of all strobes
    repeat (400) begin
      r = next_rand();
      if (r[0] && (m_free.size() != 0)) begin
        random_dispatch(r[1]);
      end
      if (r[2] && (m_release.size() != 0)) begin
        retire_i = 1'b1;
      end
      if (r[3] && (pend.size() != 0)) begin
        set_writeback(pend[next_rand() % pend.size()], next_rand());
      end
      rd_en_i = r[5:4];
      rd_preg_i[0] = rename_pkg::preg_t'(r >> 8);
      rd_preg_i[1] = rename_pkg::preg_t'(r >> 16);
      next_cycle();
    end
    repeat (2) next_cycle();

    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/rename_top.sv ====
/* Rename back end top level. Writeback goes straight to the register file and
   ready table; the free and release queues together always hold PHY minus ARCH tags. */
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        dispatch_i,
  input  rename_pkg::areg_t                           src1_areg_i,
  input  rename_pkg::areg_t                           src2_areg_i,
  input  rename_pkg::areg_t                           dst_areg_i,
  input  logic                                        writeback_i,
  input  rename_pkg::preg_t                           wb_preg_i,
  input  rename_pkg::data_t                           wb_data_i,
  input  logic                                        retire_i,
  input  logic [`RN_READ_PORT_NUM-1:0]                rd_en_i,
  input  rename_pkg::preg_t [`RN_READ_PORT_NUM-1:0]   rd_preg_i,
  output logic                                        dispatch_ready_o,
  output logic                                        renamed_o,
  output rename_pkg::preg_t                           src1_preg_o,
  output rename_pkg::preg_t                           src2_preg_o,
  output logic                                        src1_ready_o,
  output logic                                        src2_ready_o,
  output rename_pkg::preg_t                           dst_preg_o,
  output rename_pkg::data_t [`RN_READ_PORT_NUM-1:0]   rd_data_o
);

  // ========================================
  // Internal wiring
  // ========================================

  // Free queue
  logic                    free_pop;
  logic                    free_push;
  rename_pkg::preg_t       free_tag;
  rename_pkg::preg_t       free_head;
  logic                    free_empty;
  // Release queue
  logic                    release_push;
  logic                    release_pop;
  rename_pkg::preg_t       release_tag;
  rename_pkg::preg_t       release_head;
  logic                    release_empty;
  // Map and ready tables
  rename_pkg::areg_t [2:0] map_raddr;
  rename_pkg::preg_t [2:0] map_rtag;
  logic                    map_we;
  rename_pkg::areg_t       map_waddr;
  rename_pkg::preg_t       map_wtag;
  logic                    ready_clear;
  rename_pkg::preg_t       clear_tag;
  logic [1:0]              src_ready;

  rename_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .dispatch_i       (dispatch_i),
    .retire_i         (retire_i),
    .src1_areg_i      (src1_areg_i),
    .src2_areg_i      (src2_areg_i),
    .dst_areg_i       (dst_areg_i),
    .writeback_i      (writeback_i),
    .wb_preg_i        (wb_preg_i),
    .map_rtag_i       (map_rtag),
    .src_ready_i      (src_ready),
    .free_head_i      (free_head),
    .free_empty_i     (free_empty),
    .release_head_i   (release_head),
    .release_empty_i  (release_empty),
    .map_raddr_o      (map_raddr),
    .free_pop_o       (free_pop),
    .free_push_o      (free_push),
    .free_tag_o       (free_tag),
    .release_push_o   (release_push),
    .release_tag_o    (release_tag),
    .release_pop_o    (release_pop),
    .map_we_o         (map_we),
    .map_waddr_o      (map_waddr),
    .map_wtag_o       (map_wtag),
    .ready_clear_o    (ready_clear),
    .clear_tag_o      (clear_tag),
    .dispatch_ready_o (dispatch_ready_o),
    .renamed_o        (renamed_o),
    .src1_preg_o      (src1_preg_o),
    .src2_preg_o      (src2_preg_o),
    .src1_ready_o     (src1_ready_o),
    .src2_ready_o     (src2_ready_o),
    .dst_preg_o       (dst_preg_o)
  );

  // ========================================
  // Datapath blocks
  // ========================================

  // Initially free tags sit above the identity-mapped range
  tag_queue #(
    .DEPTH      (`RN_PHY_REG_NUM - `RN_ARCH_REG_NUM),
    .FILL_BASE  (`RN_ARCH_REG_NUM),
    .FILL_COUNT (`RN_PHY_REG_NUM - `RN_ARCH_REG_NUM)
  ) u_free_q (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (free_push),
    .push_tag_i (free_tag),
    .pop_i      (free_pop),
    .head_o     (free_head),
    .empty_o    (free_empty)
  );

  // Previous mappings in dispatch order, empty at reset
  tag_queue #(
    .DEPTH      (`RN_PHY_REG_NUM - `RN_ARCH_REG_NUM),
    .FILL_BASE  (0),
    .FILL_COUNT (0)
  ) u_release_q (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (release_push),
    .push_tag_i (release_tag),
    .pop_i      (release_pop),
    .head_o     (release_head),
    .empty_o    (release_empty)
  );

  map_table u_map (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (map_raddr),
    .we_i    (map_we),
    .waddr_i (map_waddr),
    .wtag_i  (map_wtag),
    .rtag_o  (map_rtag)
  );

  // Source tags only
  ready_table u_ready (
    .clk         (clk),
    .rst_n       (rst_n),
    .rtag_i      (map_rtag[1:0]),
    .clear_i     (ready_clear),
    .clear_tag_i (clear_tag),
    .set_i       (writeback_i),
    .set_tag_i   (wb_preg_i),
    .ready_o     (src_ready)
  );

  phys_reg_file #(
    .READ_PORT_NUM  (`RN_READ_PORT_NUM),
    .WRITE_PORT_NUM (1)
  ) u_prf (
    .clk     (clk),
    .rst_n   (rst_n),
    .re_i    (rd_en_i),
    .we_i    (writeback_i),
    .raddr_i (rd_preg_i),
    .waddr_i (wb_preg_i),
    .data_i  (wb_data_i),
    .data_o  (rd_data_o)
  );

endmodule

// ==== hw/rename_ctrl.sv ====
/* Single-wide rename control; strobes carry no back-pressure.
   Dispatch needs dispatch_ready_o high; retire needs an unreleased mapping. */
`timescale 1ns/1ps

module rename_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    dispatch_i,
  input  logic                    retire_i,
  input  rename_pkg::areg_t       src1_areg_i,
  input  rename_pkg::areg_t       src2_areg_i,
  input  rename_pkg::areg_t       dst_areg_i,
  input  logic                    writeback_i,
  input  rename_pkg::preg_t       wb_preg_i,
  input  rename_pkg::preg_t [2:0] map_rtag_i,
  input  logic [1:0]              src_ready_i,
  input  rename_pkg::preg_t       free_head_i,
  input  logic                    free_empty_i,
  input  rename_pkg::preg_t       release_head_i,
  input  logic                    release_empty_i,
  output rename_pkg::areg_t [2:0] map_raddr_o,
  output logic                    free_pop_o,
  output logic                    free_push_o,
  output rename_pkg::preg_t       free_tag_o,
  output logic                    release_push_o,
  output rename_pkg::preg_t       release_tag_o,
  output logic                    release_pop_o,
  output logic                    map_we_o,
  output rename_pkg::areg_t       map_waddr_o,
  output rename_pkg::preg_t       map_wtag_o,
  output logic                    ready_clear_o,
  output rename_pkg::preg_t       clear_tag_o,
  output logic                    dispatch_ready_o,
  output logic                    renamed_o,
  output rename_pkg::preg_t       src1_preg_o,
  output rename_pkg::preg_t       src2_preg_o,
  output logic                    src1_ready_o,
  output logic                    src2_ready_o,
  output rename_pkg::preg_t       dst_preg_o
);

  // ========================================
  // Dispatch path
  // ========================================

  // Lookup order: src1, src2, old dst
  assign map_raddr_o = {dst_areg_i, src2_areg_i, src1_areg_i};

  // Any free tag lets one instruction in
  assign dispatch_ready_o = !free_empty_i;

  // Allocate free head as new dst mapping
  assign free_pop_o  = dispatch_i;
  assign map_we_o    = dispatch_i;
  assign map_waddr_o = dst_areg_i;
  assign map_wtag_o  = free_head_i;

  // Old dst mapping waits for retire
  assign release_push_o = dispatch_i;
  assign release_tag_o  = map_rtag_i[2];

  // New tag not ready until its writeback
  assign ready_clear_o = dispatch_i;
  assign clear_tag_o   = free_head_i;

  // ========================================
  // Retire path
  // ========================================

  // Oldest previous mapping back to the free pool
  assign release_pop_o = retire_i;
  assign free_push_o   = retire_i;
  assign free_tag_o    = release_head_i;

  // ========================================
  // Renamed result, one cycle after dispatch
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      renamed_o <= 1'b0;
    end else begin
      renamed_o <= dispatch_i;
    end
  end

  // Payload only meaningful with renamed_o
  always_ff @(posedge clk) begin
    if (dispatch_i) begin
      src1_preg_o  <= map_rtag_i[0];
      src2_preg_o  <= map_rtag_i[1];
      src1_ready_o <= src_ready_i[0];
      src2_ready_o <= src_ready_i[1];
      dst_preg_o   <= free_head_i;
    end
  end

  a_dispatch_legal : assert property (@(posedge clk) disable iff (!rst_n)
    dispatch_i |-> !free_empty_i);
  a_retire_legal : assert property (@(posedge clk) disable iff (!rst_n)
    retire_i |-> !release_empty_i);
  // Tag being allocated still holds its old ready bit, so a writeback is stray
  a_wb_not_alloc : assert property (@(posedge clk) disable iff (!rst_n)
    (writeback_i && dispatch_i) |-> (wb_preg_i != free_head_i));

endmodule

// ==== hw/ready_table.sv ====
/* Ready bit per physical tag; tags mapped at reset start ready.
   Clear wins over a same-cycle set of the same tag. */
`timescale 1ns/1ps
`include "rename_settings.svh"

module ready_table (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rename_pkg::preg_t [1:0] rtag_i,
  input  logic                    clear_i,
  input  rename_pkg::preg_t       clear_tag_i,
  input  logic                    set_i,
  input  rename_pkg::preg_t       set_tag_i,
  output logic [1:0]              ready_o
);

  logic [`RN_PHY_REG_NUM-1:0] ready_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RN_PHY_REG_NUM; i++) begin
        ready_q[i] <= (i < `RN_ARCH_REG_NUM);
      end
    end else begin
      if (set_i) begin
        ready_q[set_tag_i] <= 1'b1;
      end
      // Later assignment gives clear priority
      if (clear_i) begin
        ready_q[clear_tag_i] <= 1'b0;
      end
    end
  end

  // Stored bit or writeback landing this cycle
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      ready_o[k] = ready_q[rtag_i[k]] | (set_i && (set_tag_i == rtag_i[k]));
    end
  end

  // Each allocation gets exactly one writeback
  a_wb_not_ready : assert property (@(posedge clk) disable iff (!rst_n)
    set_i |-> !ready_q[set_tag_i]);

endmodule

// ==== hw/map_table.sv ====
/* Speculative rename map, identity after reset.
   Lookups return the contents from before the same-cycle write. */
`timescale 1ns/1ps
`include "rename_settings.svh"

module map_table (
  input  logic                   clk,
  input  logic                   rst_n,
  // Lookups: 0 src1, 1 src2, 2 dst
  input  rename_pkg::areg_t [2:0] raddr_i,
  input  logic                   we_i,
  input  rename_pkg::areg_t      waddr_i,
  input  rename_pkg::preg_t      wtag_i,
  output rename_pkg::preg_t [2:0] rtag_o
);

  // One tag per architectural register
  rename_pkg::preg_t map_q [`RN_ARCH_REG_NUM];

  // ========================================
  // Update
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Arch reg i starts on phys reg i
      for (int i = 0; i < `RN_ARCH_REG_NUM; i++) begin
        map_q[i] <= rename_pkg::preg_t'(i);
      end
    end else if (we_i) begin
      map_q[waddr_i] <= wtag_i;
    end
  end

  // ========================================
  // Lookup
  // ========================================

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      rtag_o[k] = map_q[raddr_i[k]];
    end
  end

endmodule

// ==== hw/tag_queue.sv ====
/* FIFO of physical tags; reset preloads FILL_COUNT ascending tags from FILL_BASE.
   FILL_COUNT must not exceed DEPTH; push when full and pop when empty are illegal. */
`timescale 1ns/1ps

module tag_queue #(
  parameter int DEPTH      = 32,
  parameter int FILL_BASE  = 0,
  parameter int FILL_COUNT = 0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_i,
  input  rename_pkg::preg_t push_tag_i,
  input  logic              pop_i,
  output rename_pkg::preg_t head_o,
  output logic              empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  rename_pkg::preg_t mem [DEPTH];
  logic [PTR_W-1:0]  head_q;
  logic [PTR_W-1:0]  tail_q;
  logic [CNT_W-1:0]  count_q;
  logic              full;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == CNT_W'(DEPTH));
  assign head_o  = mem[head_q];

  // ========================================
  // Storage, preloaded at reset
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= (i < FILL_COUNT) ? rename_pkg::preg_t'(FILL_BASE + i) : '0;
      end
    end else if (push_i) begin
      mem[tail_q] <= push_tag_i;
    end
  end

  // ========================================
  // Pointers and occupancy
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      // Tail sits just past the preloaded tags
      tail_q  <= PTR_W'(FILL_COUNT % DEPTH);
      count_q <= CNT_W'(FILL_COUNT);
    end else begin
      if (pop_i) begin
        head_q <= (head_q == PTR_W'(DEPTH - 1)) ? '0 : head_q + 1'b1;
      end
      if (push_i) begin
        tail_q <= (tail_q == PTR_W'(DEPTH - 1)) ? '0 : tail_q + 1'b1;
      end
      // Push and pop together keep the count
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Overflow or underflow would corrupt the tag pool
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !full);
  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty_o);

endmodule

// ==== hw/phys_reg_file.sv ====
/* Register array has no reset, so a tag reads X until first written.
   Same-cycle write is forwarded to reads; a disabled read port gives zero. */
`timescale 1ns/1ps
`include "rename_settings.svh"

module phys_reg_file #(
  parameter int READ_PORT_NUM  = 2,
  parameter int WRITE_PORT_NUM = 1
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic [READ_PORT_NUM-1:0]                    re_i,
  input  logic [WRITE_PORT_NUM-1:0]                   we_i,
  input  rename_pkg::preg_t [READ_PORT_NUM-1:0]       raddr_i,
  input  rename_pkg::preg_t [WRITE_PORT_NUM-1:0]      waddr_i,
  input  rename_pkg::data_t [WRITE_PORT_NUM-1:0]      data_i,
  output rename_pkg::data_t [READ_PORT_NUM-1:0]       data_o
);

  // Storage, one word per physical tag
  rename_pkg::data_t reg_file [`RN_PHY_REG_NUM];

  // ========================================
  // Write side
  // ========================================

  always_ff @(posedge clk) begin
    for (int j = 0; j < WRITE_PORT_NUM; j++) begin
      if (we_i[j]) begin
        reg_file[waddr_i[j]] <= data_i[j];
      end
    end
  end

  // ========================================
  // Read side with bypass
  // ========================================

  always_comb begin
    for (int i = 0; i < READ_PORT_NUM; i++) begin
      // Idle port drives zero
      data_o[i] = '0;
      if (re_i[i]) begin
        data_o[i] = reg_file[raddr_i[i]];
        // Forward data of the matching write port
        for (int j = 0; j < WRITE_PORT_NUM; j++) begin
          if (we_i[j] && (waddr_i[j] == raddr_i[i])) begin
            data_o[i] = data_i[j];
          end
        end
      end
    end
  end

  // Two ports hitting one tag would leave the result order-dependent
  for (genvar i = 0; i < WRITE_PORT_NUM; i++) begin : g_wr_chk
    for (genvar j = i + 1; j < WRITE_PORT_NUM; j++) begin : g_pair
      a_no_dup_write : assert property (@(posedge clk) disable iff (!rst_n)
        !(we_i[i] && we_i[j] && (waddr_i[i] == waddr_i[j])));
    end
  end

endmodule

// ==== hw/rename_pkg.sv ====
/* Shared rename types. Widths derive from the counts in the settings header. */
`include "rename_settings.svh"

package rename_pkg;

  // ========================================
  // Index and tag types
  // ========================================

  // Architectural register index
  typedef logic [$clog2(`RN_ARCH_REG_NUM)-1:0] areg_t;

  // Physical register tag
  typedef logic [$clog2(`RN_PHY_REG_NUM)-1:0] preg_t;

  // ========================================
  // Payload types
  // ========================================

  // One register data word
  typedef logic [`RN_DATA_WIDTH-1:0] data_t;

endpackage

// ==== hw/rename_settings.svh ====
/* Register counts and widths for the rename back end.
   Arch count must stay below the physical count; both are powers of two. */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// ========================================
// Register counts
// ========================================

// Architectural registers seen by software
`define RN_ARCH_REG_NUM 32

// Physical registers behind the map
`define RN_PHY_REG_NUM 64

// ========================================
// Datapath
// ========================================

// Width of one register word
`define RN_DATA_WIDTH 32

// Operand read ports on the register file
`define RN_READ_PORT_NUM 2

`endif
